// ==== design/dma_pkg.sv ====
package dma_pkg;

    localparam int NUM_STREAMS = 4;
    localparam int BUS_W = 32;
    localparam int BYTE_W = 8;
    localparam int STRB_W = BUS_W / BYTE_W;
    localparam int WADDR_W = 5;

    // word addresses
    localparam int LISR_ADDR = 0;
    localparam int LIFCR_ADDR = 1;
    localparam int STREAM_BASE = 2;
    localparam int STREAM_STRIDE = 5;   // words per stream block

    localparam int CR_OFS = 0;
    localparam int NDTR_OFS = 1;
    localparam int PAR_OFS = 2;
    localparam int M0AR_OFS = 3;
    localparam int FCR_OFS = 4;

    localparam int FIFO_BYTES = 16;

    // bits in a stream's status/clear byte
    localparam int FEIF_BIT = 0;
    localparam int TEIF_BIT = 3;
    localparam int HTIF_BIT = 4;
    localparam int TCIF_BIT = 5;

    // CR fields, lsb of multi-bit fields
    localparam int CR_EN = 0;
    localparam int CR_TEIE = 2;
    localparam int CR_HTIE = 3;
    localparam int CR_TCIE = 4;
    localparam int CR_DIR = 6;
    localparam int CR_CIRC = 8;
    localparam int CR_PINC = 9;
    localparam int CR_MINC = 10;
    localparam int CR_PSIZE = 11;
    localparam int CR_MSIZE = 13;
    localparam int CR_PL = 16;
    localparam int CR_PBURST = 21;
    localparam int CR_MBURST = 23;   // straddles bytes 2 and 3

    localparam int FCR_FTH = 0;
    localparam int FCR_FS = 3;

    typedef logic [BUS_W-1:0]   word_t;
    typedef logic [WADDR_W-1:0] waddr_t;
    typedef logic [STRB_W-1:0]  strb_t;
    typedef logic [15:0]        ndt_t;

    typedef enum logic [1:0] {dir_p2m, dir_m2p, dir_m2m} dir_e;
    typedef enum logic [1:0] {size_byte, size_half, size_word} size_e;
    typedef enum logic [1:0] {burst_single, burst_inc4, burst_inc8, burst_inc16} burst_e;
    typedef enum logic [1:0] {fth_quarter, fth_half, fth_3quarter, fth_full} fth_e;
    typedef enum logic [1:0] {st_idle, st_enabling, st_active, st_disabling} stream_state_e;

    typedef struct packed {
        waddr_t addr;
        logic   rd;
        logic   wr;
        strb_t  strb;
        word_t  wdata;
    } bus_req_t;

    typedef struct packed {
        logic [STREAM_STRIDE-1:0] sel;   // one-hot, indexed by *_OFS
        strb_t                    strb;
        word_t                    wdata;
    } reg_wr_t;

    typedef struct packed {
        logic       teie;
        logic       htie;
        logic       tcie;
        dir_e       dir;
        logic       circ;
        logic       pinc;
        logic       minc;
        size_e      psize;
        size_e      msize;
        logic [1:0] pl;
        burst_e     pburst;
        burst_e     mburst;
        word_t      par;
        word_t      m0ar;
        fth_e       fth;
    } stream_cfg_t;

    typedef struct packed {
        logic       decr;
        logic       idle;
        logic [1:0] fifo_lvl;
        logic       fifo_empty;
        logic       fifo_full;
        logic       te_set;
        logic       fe_set;
    } engine_stat_t;

    typedef struct packed {
        logic tc_set;
        logic ht_set;
        logic fth_err;
    } stream_flags_t;

    typedef struct packed {
        logic tc;
        logic ht;
        logic te;
        logic fe;
    } isr_flags_t;

    // replace the strobed byte lanes of old_w
    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t strb);
        word_t w;
        w = old_w;
        for (int b = 0; b < STRB_W; b++) begin
            if (strb[b]) begin
                w[b*BYTE_W +: BYTE_W] = new_w[b*BYTE_W +: BYTE_W];
            end
        end
        return w;
    endfunction

    function automatic word_t cr_image(stream_cfg_t cfg, logic en);
        word_t w;
        w = '0;
        w[CR_EN] = en;
        w[CR_TEIE] = cfg.teie;
        w[CR_HTIE] = cfg.htie;
        w[CR_TCIE] = cfg.tcie;
        w[CR_DIR +: 2] = cfg.dir;
        w[CR_CIRC] = cfg.circ;
        w[CR_PINC] = cfg.pinc;
        w[CR_MINC] = cfg.minc;
        w[CR_PSIZE +: 2] = cfg.psize;
        w[CR_MSIZE +: 2] = cfg.msize;
        w[CR_PL +: 2] = cfg.pl;
        w[CR_PBURST +: 2] = cfg.pburst;
        w[CR_MBURST +: 2] = cfg.mburst;
        return w;
    endfunction

endpackage

// ==== design/dma_bus_port.sv ====
`timescale 1ns/1ps

module dma_bus_port (
    input  dma_pkg::bus_req_t                i_bus,
    input  dma_pkg::stream_cfg_t             i_cfg   [dma_pkg::NUM_STREAMS],
    input  logic [dma_pkg::NUM_STREAMS-1:0]  i_en,
    input  dma_pkg::ndt_t                    i_ndtr  [dma_pkg::NUM_STREAMS],
    input  dma_pkg::engine_stat_t            i_eng   [dma_pkg::NUM_STREAMS],
    input  dma_pkg::isr_flags_t              i_flags [dma_pkg::NUM_STREAMS],
    output dma_pkg::reg_wr_t                 o_wr    [dma_pkg::NUM_STREAMS],
    output dma_pkg::word_t                   o_clr,
    output dma_pkg::word_t                   o_rdata
);

    import dma_pkg::*;

    logic [STREAM_STRIDE-1:0] hit [NUM_STREAMS];
    word_t                    fcr [NUM_STREAMS];
    word_t                    lisr;
    logic                     lisr_hit;
    logic                     lifcr_hit;

    assign lisr_hit = (i_bus.addr == waddr_t'(LISR_ADDR));
    assign lifcr_hit = (i_bus.addr == waddr_t'(LIFCR_ADDR));

    // stream register decode
    always_comb begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            for (int r = 0; r < STREAM_STRIDE; r++) begin
                hit[s][r] = (i_bus.addr == waddr_t'(STREAM_BASE + s*STREAM_STRIDE + r));
            end
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            o_wr[s].sel = i_bus.wr ? hit[s] : '0;
            o_wr[s].strb = i_bus.strb;
            o_wr[s].wdata = i_bus.wdata;
        end
    end

    // unstrobed lanes clear nothing
    assign o_clr = (i_bus.wr && lifcr_hit) ? merge_bytes('0, i_bus.wdata, i_bus.strb) : '0;

    always_comb begin
        for (int s = 0; s < NUM_STREAMS; s++) begin
            fcr[s] = '0;
            fcr[s][FCR_FTH +: 2] = i_cfg[s].fth;
            if (i_eng[s].fifo_empty) begin
                fcr[s][FCR_FS +: 3] = 3'd4;
            end else if (i_eng[s].fifo_full) begin
                fcr[s][FCR_FS +: 3] = 3'd5;
            end else begin
                fcr[s][FCR_FS +: 3] = {1'b0, i_eng[s].fifo_lvl};
            end
        end
    end

    always_comb begin
        lisr = '0;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            lisr[s*BYTE_W + FEIF_BIT] = i_flags[s].fe;
            lisr[s*BYTE_W + TEIF_BIT] = i_flags[s].te;
            lisr[s*BYTE_W + HTIF_BIT] = i_flags[s].ht;
            lisr[s*BYTE_W + TCIF_BIT] = i_flags[s].tc;
        end
    end

    // LIFCR and unmapped words fall through as zero
    always_comb begin
        o_rdata = '0;
        if (i_bus.rd) begin
            if (lisr_hit) begin
                o_rdata = lisr;
            end
            for (int s = 0; s < NUM_STREAMS; s++) begin
                if (hit[s][CR_OFS]) o_rdata = cr_image(i_cfg[s], i_en[s]);
                if (hit[s][NDTR_OFS]) o_rdata = word_t'(i_ndtr[s]);   // zero-extended
                if (hit[s][PAR_OFS]) o_rdata = i_cfg[s].par;
                if (hit[s][M0AR_OFS]) o_rdata = i_cfg[s].m0ar;
                if (hit[s][FCR_OFS]) o_rdata = fcr[s];
            end
        end
    end

endmodule

// ==== design/dma_stream_cfg.sv ====
`timescale 1ns/1ps

module dma_stream_cfg (
    input  logic                 i_clk,
    input  logic                 i_nreset,
    input  dma_pkg::reg_wr_t     i_wr,
    input  logic                 i_en,
    output dma_pkg::stream_cfg_t o_cfg
);

    import dma_pkg::*;

    stream_cfg_t cfg_q;
    word_t       cr_new;
    logic        cr_wr;
    logic        wr_open;   // stream stopped, everything writable

    assign cr_wr = i_wr.sel[CR_OFS];
    assign wr_open = ~i_en;

    // strobed bytes merged over the current CR contents
    assign cr_new = merge_bytes(cr_image(cfg_q, 1'b0), i_wr.wdata, i_wr.strb);

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            cfg_q <= '0;
        end else begin
            // interrupt enables stay writable while running
            if (cr_wr) begin
                cfg_q.teie <= cr_new[CR_TEIE];
                cfg_q.htie <= cr_new[CR_HTIE];
                cfg_q.tcie <= cr_new[CR_TCIE];
            end
            if (cr_wr && wr_open) begin
                cfg_q.dir <= dir_e'(cr_new[CR_DIR +: 2]);
                cfg_q.circ <= cr_new[CR_CIRC];
                cfg_q.pinc <= cr_new[CR_PINC];
                cfg_q.minc <= cr_new[CR_MINC];
                cfg_q.psize <= size_e'(cr_new[CR_PSIZE +: 2]);
                cfg_q.msize <= size_e'(cr_new[CR_MSIZE +: 2]);
                cfg_q.pl <= cr_new[CR_PL +: 2];
                cfg_q.pburst <= burst_e'(cr_new[CR_PBURST +: 2]);
                cfg_q.mburst <= burst_e'(cr_new[CR_MBURST +: 2]);
            end
            if (i_wr.sel[PAR_OFS] && wr_open) begin
                cfg_q.par <= merge_bytes(cfg_q.par, i_wr.wdata, i_wr.strb);
            end
            if (i_wr.sel[M0AR_OFS] && wr_open) begin
                cfg_q.m0ar <= merge_bytes(cfg_q.m0ar, i_wr.wdata, i_wr.strb);
            end
            if (i_wr.sel[FCR_OFS] && i_wr.strb[0] && wr_open) begin
                cfg_q.fth <= fth_e'(i_wr.wdata[FCR_FTH +: 2]);   // FS is read-only
            end
        end
    end

    assign o_cfg = cfg_q;

endmodule

// ==== design/dma_stream_ctrl.sv ====
`timescale 1ns/1ps

module dma_stream_ctrl (
    input  logic                   i_clk,
    input  logic                   i_nreset,
    input  dma_pkg::reg_wr_t       i_wr,
    input  dma_pkg::stream_cfg_t   i_cfg,
    input  dma_pkg::engine_stat_t  i_eng,
    output logic                   o_en,
    output dma_pkg::ndt_t          o_ndtr,
    output logic                   o_dis_stream,
    output dma_pkg::stream_flags_t o_flags
);

    import dma_pkg::*;

    stream_state_e state_q;
    ndt_t          ndtr_q;
    ndt_t          shadow_q;
    ndt_t          ndtr_dec;
    logic          en_wr;
    logic          dis_wr;
    logic          count;
    logic          tc_hit;
    logic          ht_hit;
    logic          fth_ok;
    logic [6:0]    thr_bytes;
    logic [6:0]    mem_bytes;
    logic [6:0]    per_bytes;

    // bytes moved by one burst on one side
    function automatic logic [6:0] burst_bytes(size_e size, burst_e burst);
        logic [2:0] sh;
        case (size)
            size_byte: sh = 3'd0;
            size_half: sh = 3'd1;
            default:   sh = 3'd2;
        endcase
        case (burst)
            burst_inc4:  sh = sh + 3'd2;
            burst_inc8:  sh = sh + 3'd3;
            burst_inc16: sh = sh + 3'd4;
            default:     sh = sh;
        endcase
        return 7'd1 << sh;
    endfunction

    assign thr_bytes = 7'(FIFO_BYTES / 4) * (7'(i_cfg.fth) + 7'd1);
    assign mem_bytes = burst_bytes(i_cfg.msize, i_cfg.mburst);
    assign per_bytes = burst_bytes(i_cfg.psize, i_cfg.pburst);
    assign fth_ok = (thr_bytes >= mem_bytes) && (thr_bytes >= per_bytes);

    // EN lives in byte 0
    assign en_wr = i_wr.sel[CR_OFS] & i_wr.strb[0] & i_wr.wdata[CR_EN];
    assign dis_wr = i_wr.sel[CR_OFS] & i_wr.strb[0] & ~i_wr.wdata[CR_EN];

    assign count = (state_q == st_active) & i_eng.decr & (ndtr_q != '0);
    assign ndtr_dec = ndtr_q - 16'd1;
    assign tc_hit = count & (ndtr_dec == '0);
    assign ht_hit = count & (ndtr_dec == (shadow_q >> 1));

    always_ff @(posedge i_clk or negedge i_nreset) begin
        if (!i_nreset) begin
            state_q <= st_idle;
            ndtr_q <= '0;
            shadow_q <= '0;
        end else begin
            case (state_q)
                st_idle: begin
                    if (en_wr) begin
                        state_q <= st_enabling;
                        ndtr_q <= shadow_q;
                    end else if (i_wr.sel[NDTR_OFS]) begin
                        ndtr_q <= ndt_t'(merge_bytes(word_t'(ndtr_q), i_wr.wdata, i_wr.strb));
                        shadow_q <= ndt_t'(merge_bytes(word_t'(shadow_q), i_wr.wdata, i_wr.strb));
                    end
                end
                st_enabling: begin
                    state_q <= fth_ok ? st_active : st_idle;
                end
                st_active: begin
                    if (tc_hit && i_cfg.circ) begin
                        ndtr_q <= shadow_q;   // circular reload
                    end else if (count) begin
                        ndtr_q <= ndtr_dec;
                    end
                    if (tc_hit && !i_cfg.circ) begin
                        state_q <= st_idle;
                    end else if (dis_wr) begin
                        state_q <= st_disabling;
                    end
                end
                st_disabling: begin
                    if (i_eng.idle) begin
                        state_q <= st_idle;   // engine drained
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    assign o_en = (state_q == st_active) || (state_q == st_disabling);
    assign o_dis_stream = (state_q == st_disabling);
    assign o_ndtr = ndtr_q;

    assign o_flags.tc_set = tc_hit;
    assign o_flags.ht_set = ht_hit;
    assign o_flags.fth_err = (state_q == st_enabling) & ~fth_ok;

endmodule

// ==== design/dma_isr.sv ====
`timescale 1ns/1ps

module dma_isr (
    input  logic                   i_clk,
    input  logic                   i_nreset,
    input  dma_pkg::stream_flags_t i_flags [dma_pkg::NUM_STREAMS],
    input  dma_pkg::engine_stat_t  i_eng   [dma_pkg::NUM_STREAMS],
    input  dma_pkg::word_t         i_clr,
    output dma_pkg::isr_flags_t    o_flags [dma_pkg::NUM_STREAMS]
);

    import dma_pkg::*;

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
        logic [BYTE_W-1:0] clr;
        logic              fe_set;

        assign clr = i_clr[s*BYTE_W +: BYTE_W];   // this stream's LIFCR byte
        assign fe_set = i_eng[s].fe_set | i_flags[s].fth_err;

        // set beats a clear in the same cycle
        always_ff @(posedge i_clk or negedge i_nreset) begin
            if (!i_nreset) begin
                o_flags[s] <= '0;
            end else begin
                o_flags[s].tc <= i_flags[s].tc_set | (o_flags[s].tc & ~clr[TCIF_BIT]);
                o_flags[s].ht <= i_flags[s].ht_set | (o_flags[s].ht & ~clr[HTIF_BIT]);
                o_flags[s].te <= i_eng[s].te_set | (o_flags[s].te & ~clr[TEIF_BIT]);
                o_flags[s].fe <= fe_set | (o_flags[s].fe & ~clr[FEIF_BIT]);
            end
        end
    end

endmodule

// ==== design/dma_regs_top.sv ====
`timescale 1ns/1ps

module dma_regs_top (
    input  logic                            i_clk,
    input  logic                            i_nreset,
    input  dma_pkg::bus_req_t               i_bus,
    input  dma_pkg::engine_stat_t           i_eng        [dma_pkg::NUM_STREAMS],
    output dma_pkg::word_t                  o_rdata,
    output dma_pkg::stream_cfg_t            o_cfg        [dma_pkg::NUM_STREAMS],
    output logic [dma_pkg::NUM_STREAMS-1:0] o_en,
    output dma_pkg::ndt_t                   o_ndtr       [dma_pkg::NUM_STREAMS],
    output logic [dma_pkg::NUM_STREAMS-1:0] o_dis_stream,
    output dma_pkg::isr_flags_t             o_flags      [dma_pkg::NUM_STREAMS]
);

    import dma_pkg::*;

    reg_wr_t       wr [NUM_STREAMS];
    stream_flags_t ev [NUM_STREAMS];   // per-stream flag events
    word_t         clr;

    dma_bus_port u_bus_port (
        .i_bus   (i_bus),
        .i_cfg   (o_cfg),
        .i_en    (o_en),
        .i_ndtr  (o_ndtr),
        .i_eng   (i_eng),
        .i_flags (o_flags),
        .o_wr    (wr),
        .o_clr   (clr),
        .o_rdata (o_rdata)
    );

    for (genvar s = 0; s < NUM_STREAMS; s++) begin : g_stream
        dma_stream_cfg u_cfg (
            .i_clk    (i_clk),
            .i_nreset (i_nreset),
            .i_wr     (wr[s]),
            .i_en     (o_en[s]),
            .o_cfg    (o_cfg[s])
        );

        dma_stream_ctrl u_ctrl (
            .i_clk        (i_clk),
            .i_nreset     (i_nreset),
            .i_wr         (wr[s]),
            .i_cfg        (o_cfg[s]),
            .i_eng        (i_eng[s]),
            .o_en         (o_en[s]),
            .o_ndtr       (o_ndtr[s]),
            .o_dis_stream (o_dis_stream[s]),
            .o_flags      (ev[s])
        );
    end

    dma_isr u_isr (
        .i_clk    (i_clk),
        .i_nreset (i_nreset),
        .i_flags  (ev),
        .i_eng    (i_eng),
        .i_clr    (clr),
        .o_flags  (o_flags)
    );

endmodule

// ==== sim/dma_ref_model.svh ====
localparam word_t CR_RW = 32'h01E3_7FDC;       // every CR field except EN
localparam word_t CR_RUN_RW = 32'h0000_001C;   // TEIE, HTIE, TCIE

word_t         ref_cr     [NUM_STREAMS];   // EN kept apart in ref_state
word_t         ref_par    [NUM_STREAMS];
word_t         ref_m0ar   [NUM_STREAMS];
logic [1:0]    ref_fth    [NUM_STREAMS];
ndt_t          ref_ndtr   [NUM_STREAMS];
ndt_t          ref_shadow [NUM_STREAMS];
stream_state_e ref_state  [NUM_STREAMS];
isr_flags_t    ref_flags  [NUM_STREAMS];

function automatic word_t byte_lanes(strb_t strb);
    word_t m;
    m = '0;
    for (int b = 0; b < STRB_W; b++) begin
        if (strb[b]) begin
            m[b*BYTE_W +: BYTE_W] = '1;
        end
    end
    return m;
endfunction

function automatic int burst_beats(logic [1:0] code);
    case (code)
        2'd0: return 1;
        2'd1: return 4;
        2'd2: return 8;
        default: return 16;
    endcase
endfunction

// FIFO threshold in bytes against one burst on each side
function automatic bit threshold_holds(word_t cr, logic [1:0] fth);
    int thr;
    int mem;
    int per;
    thr = FIFO_BYTES * (int'(fth) + 1) / 4;
    mem = (1 << int'(cr[CR_MSIZE +: 2])) * burst_beats(cr[CR_MBURST +: 2]);
    per = (1 << int'(cr[CR_PSIZE +: 2])) * burst_beats(cr[CR_PBURST +: 2]);
    return (thr >= mem) && (thr >= per);
endfunction

function automatic logic stream_running(int s);
    return (ref_state[s] == st_active) || (ref_state[s] == st_disabling);
endfunction

task automatic reset_model();
    for (int s = 0; s < NUM_STREAMS; s++) begin
        ref_cr[s] = '0;
        ref_par[s] = '0;
        ref_m0ar[s] = '0;
        ref_fth[s] = '0;
        ref_ndtr[s] = '0;
        ref_shadow[s] = '0;
        ref_state[s] = st_idle;
        ref_flags[s] = '0;
    end
endtask

task automatic step_model();
    word_t clr;
    word_t msk;
    word_t wm;
    int    base;
    logic  run;
    logic  sel_cr;
    logic  en_wr;
    logic  dis_wr;
    logic  count;
    logic  tc;
    logic  ht;
    logic  fth_fail;
    msk = byte_lanes(bus.strb);
    clr = (bus.wr && bus.addr == waddr_t'(LIFCR_ADDR)) ? (bus.wdata & msk) : '0;
    for (int s = 0; s < NUM_STREAMS; s++) begin
        base = STREAM_BASE + s*STREAM_STRIDE;
        run = stream_running(s);
        sel_cr = bus.wr && (bus.addr == waddr_t'(base + CR_OFS));
        en_wr = sel_cr && bus.strb[0] && bus.wdata[CR_EN];
        dis_wr = sel_cr && bus.strb[0] && !bus.wdata[CR_EN];
        count = (ref_state[s] == st_active) && eng[s].decr && (ref_ndtr[s] != '0);
        tc = count && (ref_ndtr[s] == 16'd1);
        ht = count && ((ref_ndtr[s] - 16'd1) == (ref_shadow[s] >> 1));
        fth_fail = (ref_state[s] == st_enabling) && !threshold_holds(ref_cr[s], ref_fth[s]);

        ref_flags[s].tc = tc | (ref_flags[s].tc & ~clr[s*BYTE_W + TCIF_BIT]);
        ref_flags[s].ht = ht | (ref_flags[s].ht & ~clr[s*BYTE_W + HTIF_BIT]);
        ref_flags[s].te = eng[s].te_set | (ref_flags[s].te & ~clr[s*BYTE_W + TEIF_BIT]);
        ref_flags[s].fe = eng[s].fe_set | fth_fail |
                          (ref_flags[s].fe & ~clr[s*BYTE_W + FEIF_BIT]);

        case (ref_state[s])
            st_idle: begin
                if (en_wr) begin
                    ref_state[s] = st_enabling;
                    ref_ndtr[s] = ref_shadow[s];
                end else if (bus.wr && bus.addr == waddr_t'(base + NDTR_OFS)) begin
                    ref_ndtr[s] = ndt_t'((word_t'(ref_ndtr[s]) & ~msk) | (bus.wdata & msk));
                    ref_shadow[s] = ndt_t'((word_t'(ref_shadow[s]) & ~msk) | (bus.wdata & msk));
                end
            end
            st_enabling: begin
                ref_state[s] = fth_fail ? st_idle : st_active;
            end
            st_active: begin
                if (tc && ref_cr[s][CR_CIRC]) begin
                    ref_ndtr[s] = ref_shadow[s];
                end else if (count) begin
                    ref_ndtr[s] = ref_ndtr[s] - 16'd1;
                end
                if (tc && !ref_cr[s][CR_CIRC]) begin
                    ref_state[s] = st_idle;
                end else if (dis_wr) begin
                    ref_state[s] = st_disabling;
                end
            end
            default: begin
                if (eng[s].idle) begin
                    ref_state[s] = st_idle;
                end
            end
        endcase

        // config storage sees EN as it was before this edge
        if (sel_cr) begin
            wm = msk & (run ? CR_RUN_RW : CR_RW);
            ref_cr[s] = (ref_cr[s] & ~wm) | (bus.wdata & wm);
        end
        if (!run && bus.wr && bus.addr == waddr_t'(base + PAR_OFS)) begin
            ref_par[s] = (ref_par[s] & ~msk) | (bus.wdata & msk);
        end
        if (!run && bus.wr && bus.addr == waddr_t'(base + M0AR_OFS)) begin
            ref_m0ar[s] = (ref_m0ar[s] & ~msk) | (bus.wdata & msk);
        end
        if (!run && bus.wr && bus.strb[0] && bus.addr == waddr_t'(base + FCR_OFS)) begin
            ref_fth[s] = bus.wdata[FCR_FTH +: 2];
        end
    end
endtask

function automatic word_t expected_rdata();
    word_t w;
    int    a;
    int    s;
    w = '0;
    a = int'(bus.addr);
    if (bus.rd && a == LISR_ADDR) begin
        for (int k = 0; k < NUM_STREAMS; k++) begin
            w[k*BYTE_W + FEIF_BIT] = ref_flags[k].fe;
            w[k*BYTE_W + TEIF_BIT] = ref_flags[k].te;
            w[k*BYTE_W + HTIF_BIT] = ref_flags[k].ht;
            w[k*BYTE_W + TCIF_BIT] = ref_flags[k].tc;
        end
    end else if (bus.rd && a >= STREAM_BASE && a < STREAM_BASE + NUM_STREAMS*STREAM_STRIDE) begin
        s = (a - STREAM_BASE) / STREAM_STRIDE;
        case ((a - STREAM_BASE) % STREAM_STRIDE)
            CR_OFS: w = ref_cr[s] | word_t'(stream_running(s));
            NDTR_OFS: w = word_t'(ref_ndtr[s]);
            PAR_OFS: w = ref_par[s];
            M0AR_OFS: w = ref_m0ar[s];
            default: begin
                w[FCR_FTH +: 2] = ref_fth[s];
                if (eng[s].fifo_empty) begin
                    w[FCR_FS +: 3] = 3'd4;
                end else if (eng[s].fifo_full) begin
                    w[FCR_FS +: 3] = 3'd5;
                end else begin
                    w[FCR_FS +: 3] = {1'b0, eng[s].fifo_lvl};
                end
            end
        endcase
    end
    return w;
endfunction

// configuration the engine should see, taken field by field from the CR bit map
function automatic stream_cfg_t expected_cfg(int s);
    stream_cfg_t c;
    c.teie = ref_cr[s][CR_TEIE];
    c.htie = ref_cr[s][CR_HTIE];
    c.tcie = ref_cr[s][CR_TCIE];
    c.dir = dir_e'(ref_cr[s][CR_DIR +: 2]);
    c.circ = ref_cr[s][CR_CIRC];
    c.pinc = ref_cr[s][CR_PINC];
    c.minc = ref_cr[s][CR_MINC];
    c.psize = size_e'(ref_cr[s][CR_PSIZE +: 2]);
    c.msize = size_e'(ref_cr[s][CR_MSIZE +: 2]);
    c.pl = ref_cr[s][CR_PL +: 2];
    c.pburst = burst_e'(ref_cr[s][CR_PBURST +: 2]);
    c.mburst = burst_e'(ref_cr[s][CR_MBURST +: 2]);
    c.par = ref_par[s];
    c.m0ar = ref_m0ar[s];
    c.fth = fth_e'(ref_fth[s]);
    return c;
endfunction

// ==== sim/tb_dma_regs.sv ====
`timescale 1ns/1ps

module tb_dma_regs;

    import dma_pkg::*;

    logic                   i_clk;
    logic                   i_nreset;
    bus_req_t               bus;
    engine_stat_t           eng   [NUM_STREAMS];
    word_t                  rdata;
    stream_cfg_t            cfg   [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] en;
    ndt_t                   ndtr  [NUM_STREAMS];
    logic [NUM_STREAMS-1:0] dis;
    isr_flags_t             flags [NUM_STREAMS];
    int                     seed;
    logic                   checking;

    `include "dma_ref_model.svh"

    dma_regs_top DUT (
        .i_clk        (i_clk),
        .i_nreset     (i_nreset),
        .i_bus        (bus),
        .i_eng        (eng),
        .o_rdata      (rdata),
        .o_cfg        (cfg),
        .o_en         (en),
        .o_ndtr       (ndtr),
        .o_dis_stream (dis),
        .o_flags      (flags)
    );

    always #4 i_clk = ~i_clk;

    task automatic abort_run();
        $display("tests failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_word(word_t got, word_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_ndt(ndt_t got, ndt_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_flags(isr_flags_t got, isr_flags_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s tc/ht/te/fe is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_cfg(stream_cfg_t got, stream_cfg_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_bits(logic [NUM_STREAMS-1:0] got, logic [NUM_STREAMS-1:0] exp,
                              string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // registered outputs are stable around the falling edge
    task automatic compare_outputs();
        logic [NUM_STREAMS-1:0] exp_en;
        logic [NUM_STREAMS-1:0] exp_dis;
        for (int s = 0; s < NUM_STREAMS; s++) begin
            exp_en[s] = stream_running(s);
            exp_dis[s] = (ref_state[s] == st_disabling);
            check_ndt(ndtr[s], ref_ndtr[s], $sformatf("o_ndtr[%0d]", s));
            check_flags(flags[s], ref_flags[s], $sformatf("o_flags[%0d]", s));
            check_cfg(cfg[s], expected_cfg(s), $sformatf("o_cfg[%0d]", s));
        end
        check_bits(en, exp_en, "o_en");
        check_bits(dis, exp_dis, "o_dis_stream");
    endtask

    always @(posedge i_clk) begin
        if (i_nreset) begin
            step_model();
        end
    end

    always @(negedge i_clk) begin
        if (checking) begin
            compare_outputs();
        end
    end

    function automatic int rand_below(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic verify_rdata();
        #2;   // combinational read settles after the falling-edge drive
        check_word(rdata, expected_rdata(), "o_rdata");
    endtask

    task automatic drive_bus(int addr, logic rd, logic wr, strb_t strb, word_t wdata);
        @(negedge i_clk);
        bus.addr = waddr_t'(addr);
        bus.rd = rd;
        bus.wr = wr;
        bus.strb = strb;
        bus.wdata = wdata;
        verify_rdata();
    endtask

    // bus stays quiet while the engine idle bit of stream s is held at drain
    task automatic wait_for_en(int s, logic val, logic drain, int limit);
        int cnt;
        cnt = 0;
        do begin
            @(negedge i_clk);
            eng[s].idle = drain;
            bus.rd = 1'b0;
            bus.wr = 1'b0;
            verify_rdata();
            cnt++;
            if (cnt > limit) begin
                $display("Timeout: EN of stream %0d did not become %0b within %0d cycles",
                         s, val, limit);
                abort_run();
            end
        end while (en[s] !== val);
    endtask

    task automatic disable_while_busy();
        drive_bus(STREAM_BASE + NDTR_OFS, 1'b0, 1'b1, 4'hf, 32'd200);
        drive_bus(STREAM_BASE + FCR_OFS, 1'b0, 1'b1, 4'h1, 32'd3);
        drive_bus(STREAM_BASE + CR_OFS, 1'b0, 1'b1, 4'hf, 32'h0000_0601);   // byte, single, EN
        wait_for_en(0, 1'b1, 1'b0, 10);
        drive_bus(STREAM_BASE + CR_OFS, 1'b0, 1'b1, 4'h1, 32'h0000_0600);
        repeat (6) begin
            drive_bus(STREAM_BASE + CR_OFS, 1'b1, 1'b0, 4'h0, '0);   // engine still draining
        end
        wait_for_en(0, 1'b0, 1'b1, 10);
    endtask

    task automatic random_cycle();
        int s;
        int r;
        int op;
        @(negedge i_clk);
        for (int k = 0; k < NUM_STREAMS; k++) begin
            eng[k].decr = (rand_below(2) == 0);
            eng[k].idle = (rand_below(4) == 0);
            eng[k].fifo_lvl = 2'(rand_below(4));
            eng[k].fifo_empty = (rand_below(4) == 0);
            eng[k].fifo_full = (rand_below(4) == 0);
            eng[k].te_set = (rand_below(16) == 0);
            eng[k].fe_set = (rand_below(16) == 0);
        end
        s = rand_below(NUM_STREAMS);
        r = rand_below(STREAM_STRIDE);
        case (rand_below(8))
            0: bus.addr = waddr_t'(rand_below(2));    // LISR or LIFCR
            1: bus.addr = waddr_t'(rand_below(32));   // unmapped words too
            default: bus.addr = waddr_t'(STREAM_BASE + s*STREAM_STRIDE + r);
        endcase
        op = rand_below(10);
        bus.rd = (op < 5);
        bus.wr = (op >= 4) && (op < 9);
        bus.strb = (rand_below(2) == 0) ? strb_t'(rand_below(16)) : 4'hf;
        bus.wdata = $random(seed);
        // keep data sizes within byte, half-word and word
        if (bus.wdata[CR_PSIZE +: 2] == 2'd3) begin
            bus.wdata[CR_PSIZE + 1] = 1'b0;
        end
        if (bus.wdata[CR_MSIZE +: 2] == 2'd3) begin
            bus.wdata[CR_MSIZE + 1] = 1'b0;
        end
        if (rand_below(2) == 0) begin
            bus.wdata[CR_PBURST +: 4] = '0;   // single beats pass the threshold more often
        end
        bus.wdata[CR_EN] = (rand_below(4) != 0);
        if (r == NDTR_OFS) begin
            bus.wdata[15:5] = '0;   // short transfers reach TC
        end
        verify_rdata();
    endtask

    initial begin
        seed = 7;
        checking = 1'b0;
        i_clk = 1'b0;
        i_nreset = 1'b0;
        bus = '0;
        for (int k = 0; k < NUM_STREAMS; k++) begin
            eng[k] = '0;
        end
        reset_model();
        repeat (8) @(negedge i_clk);
        i_nreset = 1'b1;
        checking = 1'b1;
        disable_while_busy();
        for (int n = 0; n < 4000; n++) begin
            random_cycle();
        end
        @(negedge i_clk);
        $display("all tests passed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+sim
design/dma_pkg.sv
design/dma_bus_port.sv
design/dma_stream_cfg.sv
design/dma_stream_ctrl.sv
design/dma_isr.sv
design/dma_regs_top.sv
sim/tb_dma_regs.sv

// ==== Bender.yml ====
package:
  name: dma_regs

sources:
  - files:
      - design/dma_pkg.sv
      - design/dma_bus_port.sv
      - design/dma_stream_cfg.sv
      - design/dma_stream_ctrl.sv
      - design/dma_isr.sv
      - design/dma_regs_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_dma_regs.sv
